//--- Bender.yml
package:
  name: exec_slice

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/regIdPkg.sv
      - hdl/execOpPkg.sv
      - hdl/issueStage.sv
      - hdl/regGpr.sv
      - hdl/statusReg.sv
      - hdl/aluUnit.sv
      - hdl/execSlice.sv
  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/execSliceTb.sv

//--- build.f
+incdir+hdl
+incdir+dv
hdl/regIdPkg.sv
hdl/execOpPkg.sv
hdl/issueStage.sv
hdl/regGpr.sv
hdl/statusReg.sv
hdl/aluUnit.sv
hdl/execSlice.sv
dv/execSliceTb.sv

//--- dv/gprModel.svh
// --------------------------------------
// Reference model of the banked registers,
// the status bits and the operation rules
// --------------------------------------
`ifndef GPR_MODEL_SVH
`define GPR_MODEL_SVH

regValue   modelBankA [`BANK_REGS];
regValue   modelBankB [`BANK_REGS];
regValue   modelHigh [`BANK_REGS];
statusWord modelStatus;

function automatic void resetModel();
  for (int i = 0; i < `BANK_REGS; i++) begin
    modelBankA[i] = '0;
    modelBankB[i] = '0;
    modelHigh[i]  = '0;
  end
  modelStatus = '0;
endfunction

// Upper four id bits pick the group, the low three the word
function automatic regValue readModel(regId id);
  case (id[6:3])
    `GROUP_LOW:  return modelStatus.rb ? modelBankB[id[2:0]] : modelBankA[id[2:0]];
    `GROUP_HIGH: return modelHigh[id[2:0]];
    `GROUP_ALT:  return modelStatus.rb ? modelBankA[id[2:0]] : modelBankB[id[2:0]];
    default:     return '0;
  endcase
endfunction

function automatic void writeModel(regId id, regValue value);
  case (id[6:3])
    `GROUP_LOW: begin
      if (modelStatus.rb) modelBankB[id[2:0]] = value;
      else modelBankA[id[2:0]] = value;
    end
    `GROUP_HIGH: modelHigh[id[2:0]] = value;
    `GROUP_ALT: begin
      if (modelStatus.rb) modelBankA[id[2:0]] = value;
      else modelBankB[id[2:0]] = value;
    end
    default: ;
  endcase
endfunction

// Sources are read with the status bits left by earlier operations
function automatic execResult applyModel(execOp op);
  regValue rs;
  regValue rt;
  regValue rm;
  regValue value;
  logic    writes;
  rs = readModel(op.rs);
  rt = readModel(op.rt);
  rm = readModel(op.rm);
  writes = 1'b1;
  case (op.op)
    opAdd: value = rs + rt;
    opSub: value = rs - rt;
    opAnd: value = rs & rt;
    opXor: value = rs ^ rt;
    opMov: value = rs;
    opMac: value = rs + rt * rm;
    opCmpEq: begin
      value = regValue'(rs == rt);
      modelStatus.t = (rs == rt);
      writes = 1'b0;
    end
    opSetRb: begin
      value = regValue'(op.imm);
      modelStatus.rb = op.imm;
      writes = 1'b0;
    end
    default: begin
      value = '0;
      writes = 1'b0;
    end
  endcase
  if (writes) writeModel(op.rn, value);
  return '{op: op.op, rn: op.rn, value: value};
endfunction

`endif

//--- dv/execSliceTb.sv
// --------------------------------------
// Testbench for the operand and writeback
// slice with a scoreboard against a model
// --------------------------------------
`timescale 1ns/1ps
`include "regFile_config.svh"

module execSliceTb import regIdPkg::*, execOpPkg::*;;

  logic      clock;
  logic      rstN;
  logic      opValid;
  execOp     opIn;
  logic      resultValid;
  execResult resultOut;
  statusWord status;

  int seed = 10;
  int cycleCount;
  int errorCount = 0;
  int checkCount = 0;
  int waited;

  // Expected results in issue order, each with the cycle it is due in
  execResult expResults [$];
  statusWord expStatuses [$];
  int        expDue [$];
  statusWord curStatus;

  // Word currently pushed through the write port before any operation runs
  regId    loadId;
  regValue loadValue;

  `include "gprModel.svh"

  execSlice execSlice_inst (
    .clock       (clock),
    .rstN        (rstN),
    .opValid     (opValid),
    .opIn        (opIn),
    .resultValid (resultValid),
    .resultOut   (resultOut),
    .status      (status)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock or negedge rstN) begin
    if (!rstN) cycleCount <= 0;
    else cycleCount <= cycleCount + 1;
  end

  task automatic checkValue(string what, logic [63:0] actual, logic [63:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic execOp makeOp(aluOp code, regId rn, regId rs, regId rt, regId rm,
                                   logic imm);
    return '{op: code, rn: rn, rs: rs, rt: rt, rm: rm, imm: imm};
  endfunction

  // Mostly groups 0, 1 and 4, with one id in ten from an unused group
  function automatic regId randomId();
    int         pick;
    logic [3:0] grp;
    pick = {$random(seed)} % 10;
    if (pick < 4) grp = 4'd`GROUP_LOW;
    else if (pick < 7) grp = 4'd`GROUP_HIGH;
    else if (pick < 9) grp = 4'd`GROUP_ALT;
    else begin
      grp = 4'(2 + {$random(seed)} % 14);
      if (grp == 4'd`GROUP_ALT) grp = 4'd15;
    end
    return {grp, 3'($random(seed))};
  endfunction

  function automatic execOp randomOp();
    logic [2:0] code;
    code = 3'($random(seed));
    return makeOp(aluOp'(code), randomId(), randomId(), randomId(), randomId(),
                  1'($random(seed)));
  endfunction

  // Fills bank A, bank B and the shared words with random data through the
  // register file write port while no operation is in flight, RB still 0
  task automatic preloadRegs();
    logic [3:0] groups [3];
    groups = '{4'd`GROUP_LOW, 4'd`GROUP_HIGH, 4'd`GROUP_ALT};
    for (int g = 0; g < 3; g++) begin
      for (int i = 0; i < `BANK_REGS; i++) begin
        @(negedge clock);
        loadId    = {groups[g], 3'(i)};
        loadValue = $random(seed);
        force execSlice_inst.writeValid = 1'b1;
        force execSlice_inst.writeId    = loadId;
        force execSlice_inst.writeValue = loadValue;
        writeModel(loadId, loadValue);
      end
    end
    @(negedge clock);
    release execSlice_inst.writeValid;
    release execSlice_inst.writeId;
    release execSlice_inst.writeValue;
  endtask

  // Sampled by the DUT at the next edge, reported three counts later
  task automatic sendOp(execOp op);
    @(posedge clock);
    opValid <= 1'b1;
    opIn    <= op;
    expResults.push_back(applyModel(op));
    expStatuses.push_back(modelStatus);
    expDue.push_back(cycleCount + 3);
  endtask

  task automatic idleCycle();
    @(posedge clock);
    opValid <= 1'b0;
  endtask

  // Outputs are looked at on the falling edge, halfway between updates
  always @(negedge clock) begin
    if (rstN) begin
      if (resultValid) begin
        if (expDue.size() == 0) begin
          errorCount++;
          $display("Error at %0t: result strobe without a pending operation", $time);
        end else begin
          checkValue("result cycle", cycleCount, expDue.pop_front());
          checkValue("resultOut", resultOut, expResults.pop_front());
          curStatus = expStatuses.pop_front();
        end
      end else if (expDue.size() != 0 && expDue[0] <= cycleCount) begin
        checkValue("resultValid", resultValid, 1'b1);
        void'(expDue.pop_front());
        void'(expResults.pop_front());
        curStatus = expStatuses.pop_front();
      end
      checkValue("status", status, curStatus);
    end
  end

  initial begin
    rstN    = 1'b0;
    opValid = 1'b0;
    opIn    = '0;
    resetModel();
    curStatus = '0;
    repeat (4) @(posedge clock);
    rstN <= 1'b1;

    preloadRegs();

    // Group 0 write, then the same index through group 4 before and after a bank-set
    sendOp(makeOp(opSetRb, 7'h00, 7'h00, 7'h00, 7'h00, 1'b0));
    sendOp(makeOp(opAdd, 7'h03, 7'h08, 7'h09, 7'h00, 1'b0));
    sendOp(makeOp(opMov, 7'h0a, 7'h23, 7'h00, 7'h00, 1'b0));
    sendOp(makeOp(opSetRb, 7'h00, 7'h00, 7'h00, 7'h00, 1'b1));
    sendOp(makeOp(opMov, 7'h0b, 7'h23, 7'h00, 7'h00, 1'b0));
    sendOp(makeOp(opAdd, 7'h03, 7'h0a, 7'h0b, 7'h00, 1'b0));
    sendOp(makeOp(opMov, 7'h0d, 7'h23, 7'h00, 7'h00, 1'b0));
    sendOp(makeOp(opMac, 7'h0c, 7'h08, 7'h0a, 7'h0b, 1'b0));
    idleCycle();
    // Unused groups read as zero and swallow writes
    sendOp(makeOp(opXor, 7'h50, 7'h0c, 7'h0b, 7'h00, 1'b0));
    sendOp(makeOp(opCmpEq, 7'h00, 7'h50, 7'h7f, 7'h00, 1'b0));
    sendOp(makeOp(opSetRb, 7'h00, 7'h00, 7'h00, 7'h00, 1'b0));
    sendOp(makeOp(opMov, 7'h0e, 7'h23, 7'h00, 7'h00, 1'b0));
    idleCycle();

    for (int n = 0; n < 400; n++) begin
      sendOp(randomOp());
      if ({$random(seed)} % 3 == 0) begin
        repeat ({$random(seed)} % 3 + 1) idleCycle();
      end
    end
    idleCycle();

    waited = 0;
    while (expDue.size() != 0 && waited < 20) begin
      @(posedge clock);
      waited++;
    end
    if (expDue.size() != 0) begin
      $display("Timeout: %0d results never arrived", expDue.size());
      $display("test failed");
      $finish;
    end else begin
      repeat (2) @(negedge clock);
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

//--- hdl/aluUnit.sv
// -------------------------------------
// Operation compute, write request and
// registered result
// -------------------------------------
`timescale 1ns/1ps

module aluUnit import regIdPkg::*, execOpPkg::*; (
  input  logic      clock,
  input  logic      rstN,
  input  logic      issueValid,
  input  execOp     issueOp,
  input  regValue   rsValue,
  input  regValue   rtValue,
  input  regValue   rmValue,
  input  statusWord status,
  output logic      writeValid,
  output regId      writeId,
  output regValue   writeValue,
  output logic      resultValid,
  output execResult resultOut
);

  regValue computed;
  logic    writesReg;

  always_comb begin
    writesReg = 1'b1;
    case (issueOp.op)
      opAdd:   computed = rsValue + rtValue;
      opSub:   computed = rsValue - rtValue;
      opAnd:   computed = rsValue & rtValue;
      opXor:   computed = rsValue ^ rtValue;
      opMov:   computed = rsValue;
      // Only the low word of the product is kept
      opMac:   computed = rsValue + rtValue * rmValue;
      opCmpEq: begin
        computed  = regValue'(rsValue == rtValue);
        writesReg = 1'b0;
      end
      opSetRb: begin
        computed  = regValue'(issueOp.imm);
        writesReg = 1'b0;
      end
      default: begin
        computed  = '0;
        writesReg = 1'b0;
      end
    endcase
  end

  // The register file drops writes aimed at unused groups on its own
  assign writeValid = issueValid && writesReg;
  assign writeId    = issueOp.rn;
  assign writeValue = computed;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= issueValid;
    end
  end

  always_ff @(posedge clock) begin
    if (issueValid) begin
      resultOut <= '{op: issueOp.op, rn: issueOp.rn, value: computed};
    end
  end

  // Reported compare and bank-set values agree with the status register at that edge
  assert property (@(posedge clock) disable iff (!rstN)
    resultValid && resultOut.op == opCmpEq |-> status.t == resultOut.value[0]);
  assert property (@(posedge clock) disable iff (!rstN)
    resultValid && resultOut.op == opSetRb |-> status.rb == resultOut.value[0]);

endmodule

//--- hdl/execOpPkg.sv
// -------------------------------------
// Operation, status and result types
// -------------------------------------

package execOpPkg;

  import regIdPkg::*;

  // Three bits, every code is a defined operation
  typedef enum logic [2:0] {
    opAdd,
    opSub,
    opAnd,
    opXor,
    opMov,
    opMac,
    opCmpEq,
    opSetRb
  } aluOp;

  // One issued operation, 32 bits in total
  typedef struct packed {
    aluOp op;
    regId rn;
    regId rs;
    regId rt;
    regId rm;
    logic imm;
  } execOp;

  // RB picks the active low bank, T holds the last compare outcome
  typedef struct packed {
    logic rb;
    logic t;
  } statusWord;

  // Reported for every operation, including those that write no register
  typedef struct packed {
    aluOp    op;
    regId    rn;
    regValue value;
  } execResult;

endpackage

//--- hdl/execSlice.sv
// -------------------------------------
// Operand and writeback slice top level
// -------------------------------------
`timescale 1ns/1ps

module execSlice import regIdPkg::*, execOpPkg::*; (
  input  logic      clock,
  input  logic      rstN,
  input  logic      opValid,
  input  execOp     opIn,
  output logic      resultValid,
  output execResult resultOut,
  output statusWord status
);

  logic    issueValid;
  execOp   issueOp;
  regValue rsValue;
  regValue rtValue;
  regValue rmValue;
  logic    writeValid;
  regId    writeId;
  regValue writeValue;

  issueStage issueStage_inst (
    .clock      (clock),
    .rstN       (rstN),
    .opValid    (opValid),
    .opIn       (opIn),
    .issueValid (issueValid),
    .issueOp    (issueOp)
  );

  // Reads see the RB of the issue cycle, writes land at the next edge
  regGpr regGpr_inst (
    .clock      (clock),
    .rstN       (rstN),
    .rb         (status.rb),
    .rsId       (issueOp.rs),
    .rtId       (issueOp.rt),
    .rmId       (issueOp.rm),
    .writeValid (writeValid),
    .writeId    (writeId),
    .writeValue (writeValue),
    .rsValue    (rsValue),
    .rtValue    (rtValue),
    .rmValue    (rmValue)
  );

  statusReg statusReg_inst (
    .clock      (clock),
    .rstN       (rstN),
    .issueValid (issueValid),
    .issueOp    (issueOp),
    .rsValue    (rsValue),
    .rtValue    (rtValue),
    .status     (status)
  );

  aluUnit aluUnit_inst (
    .clock       (clock),
    .rstN        (rstN),
    .issueValid  (issueValid),
    .issueOp     (issueOp),
    .rsValue     (rsValue),
    .rtValue     (rtValue),
    .rmValue     (rmValue),
    .status      (status),
    .writeValid  (writeValid),
    .writeId     (writeId),
    .writeValue  (writeValue),
    .resultValid (resultValid),
    .resultOut   (resultOut)
  );

endmodule

//--- hdl/issueStage.sv
// -------------------------------------
// Issue register for strobed operations
// -------------------------------------
`timescale 1ns/1ps

module issueStage import execOpPkg::*; (
  input  logic  clock,
  input  logic  rstN,
  input  logic  opValid,
  input  execOp opIn,
  output logic  issueValid,
  output execOp issueOp
);

  // A new strobe every cycle keeps issueValid high, one op per cycle
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      issueValid <= 1'b0;
    end else begin
      issueValid <= opValid;
    end
  end

  // Holds the last operation while nothing is issued
  always_ff @(posedge clock) begin
    if (opValid) begin
      issueOp <= opIn;
    end
  end

  property opKnownOnStrobe;
    @(posedge clock) disable iff (!rstN)
      opValid |-> !$isunknown(opIn);
  endproperty
  assert property (opKnownOnStrobe);

endmodule

//--- hdl/regFile_config.svh
// -------------------------------------
// Width, bank size and group code defines
// for the banked register file
// -------------------------------------
`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// Width of one register word
`define DATA_WIDTH 32

// A register id holds a 4-bit group above a 3-bit index
`define REG_ID_WIDTH 7

// Words per bank, also the number of shared high words
`define BANK_REGS 8

// Group codes found in the upper bits of a register id
`define GROUP_LOW 0
`define GROUP_HIGH 1
`define GROUP_ALT 4

`endif

//--- hdl/regGpr.sv
// -------------------------------------
// Banked general register file with three
// read ports, one write port and checks
// -------------------------------------
`timescale 1ns/1ps
`include "regFile_config.svh"

module regGpr import regIdPkg::*; (
  input  logic    clock,
  input  logic    rstN,
  input  logic    rb,
  input  regId    rsId,
  input  regId    rtId,
  input  regId    rmId,
  input  logic    writeValid,
  input  regId    writeId,
  input  regValue writeValue,
  output regValue rsValue,
  output regValue rtValue,
  output regValue rmValue
);

  // Low words of bank A and bank B, and the high words both banks share
  regValue bankA [`BANK_REGS];
  regValue bankB [`BANK_REGS];
  regValue highRegs [`BANK_REGS];

  regId    readIds [3];
  regValue readValues [3];

  regGroup writeGroup;
  regIndex writeIndex;

  assign readIds[0] = rsId;
  assign readIds[1] = rtId;
  assign readIds[2] = rmId;

  assign rsValue = readValues[0];
  assign rtValue = readValues[1];
  assign rmValue = readValues[2];

  // All three ports share one decode, group 4 reaches the bank RB does not pick
  always_comb begin
    for (int p = 0; p < 3; p++) begin
      case (idGroup(readIds[p]))
        groupLow:  readValues[p] = rb ? bankB[idIndex(readIds[p])] : bankA[idIndex(readIds[p])];
        groupAlt:  readValues[p] = rb ? bankA[idIndex(readIds[p])] : bankB[idIndex(readIds[p])];
        groupHigh: readValues[p] = highRegs[idIndex(readIds[p])];
        default:   readValues[p] = '0;
      endcase
    end
  end

  assign writeGroup = idGroup(writeId);
  assign writeIndex = idIndex(writeId);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `BANK_REGS; i++) begin
        bankA[i]    <= '0;
        bankB[i]    <= '0;
        highRegs[i] <= '0;
      end
    end else if (writeValid) begin
      case (writeGroup)
        groupLow: begin
          if (rb) bankB[writeIndex] <= writeValue;
          else bankA[writeIndex] <= writeValue;
        end
        groupAlt: begin
          if (rb) bankA[writeIndex] <= writeValue;
          else bankB[writeIndex] <= writeValue;
        end
        groupHigh: highRegs[writeIndex] <= writeValue;
        // Writes to unused groups are dropped
        default: ;
      endcase
    end
  end

  // Bank select and write control must be known whenever a write may happen
  assert property (@(posedge clock) disable iff (!rstN)
    !$isunknown({rb, writeValid}) && (writeValid -> !$isunknown(writeId)));

  for (genvar p = 0; p < 3; p++) begin : genZeroCheck
    assert property (@(posedge clock) disable iff (!rstN)
      idGroup(readIds[p]) == groupNone |-> readValues[p] == '0);
  end

  // With RB set a group 0 write must show up in bank B one cycle later
  property lowWriteToBankB;
    @(posedge clock) disable iff (!rstN)
      writeValid && writeGroup == groupLow && rb
        |=> bankB[$past(writeIndex)] == $past(writeValue);
  endproperty
  assert property (lowWriteToBankB);

  // Group 4 writes go to the bank opposite the RB seen at the write edge
  property altWriteOpposite;
    @(posedge clock) disable iff (!rstN)
      writeValid && writeGroup == groupAlt
        |=> ($past(rb) ? bankA[$past(writeIndex)] : bankB[$past(writeIndex)])
            == $past(writeValue);
  endproperty
  assert property (altWriteOpposite);

endmodule

//--- hdl/regIdPkg.sv
// -------------------------------------
// Register id, register word and group
// types with the id decode helpers
// -------------------------------------
`include "regFile_config.svh"

package regIdPkg;

  localparam int indexBits = $clog2(`BANK_REGS);
  localparam int groupBits = `REG_ID_WIDTH - indexBits;

  typedef logic [`REG_ID_WIDTH-1:0] regId;
  typedef logic [`DATA_WIDTH-1:0] regValue;
  typedef logic [indexBits-1:0] regIndex;

  // Any group code other than these three maps to groupNone
  typedef enum logic [groupBits-1:0] {
    groupLow  = `GROUP_LOW,
    groupHigh = `GROUP_HIGH,
    groupAlt  = `GROUP_ALT,
    groupNone = (1 << groupBits) - 1
  } regGroup;

  function automatic regGroup idGroup(regId id);
    logic [groupBits-1:0] code;
    code = id[`REG_ID_WIDTH-1 -: groupBits];
    case (code)
      `GROUP_LOW:  return groupLow;
      `GROUP_HIGH: return groupHigh;
      `GROUP_ALT:  return groupAlt;
      default:     return groupNone;
    endcase
  endfunction

  function automatic regIndex idIndex(regId id);
    return id[indexBits-1:0];
  endfunction

endpackage

//--- hdl/statusReg.sv
// -------------------------------------
// Status register holding RB and T
// -------------------------------------
`timescale 1ns/1ps

module statusReg import regIdPkg::*, execOpPkg::*; (
  input  logic      clock,
  input  logic      rstN,
  input  logic      issueValid,
  input  execOp     issueOp,
  input  regValue   rsValue,
  input  regValue   rtValue,
  output statusWord status
);

  // Both bits change at the same edge that reports the result
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      status <= '0;
    end else if (issueValid) begin
      case (issueOp.op)
        opCmpEq: status.t <= (rsValue == rtValue);
        opSetRb: status.rb <= issueOp.imm;
        default: ;
      endcase
    end
  end

  // A bank switch is only ever caused by an issued bank-set
  property rbOnlyOnSetRb;
    @(posedge clock) disable iff (!rstN)
      $changed(status.rb) |-> $past(issueValid) && $past(issueOp.op) == opSetRb;
  endproperty
  assert property (rbOnlyOnSetRb);

endmodule
